/* list.f */
logic/video_pkg.sv
logic/dl_pkg.sv
logic/rom_loader.sv
logic/video_timer.sv
logic/pixel_mux.sv
logic/game_video_top.sv
verif/mist_test.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it into a log, look for the pass line

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -f list.f --top-module mist_test -o sim_bin
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim_bin > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Test OK" "$log"; then
    echo "simulation passed"
    exit 0
fi

echo "simulation failed, see $log"
exit 1

/* verif/mist_test.sv */
`timescale 1ns/100ps

module mist_test;
    import video_pkg::*;
    import dl_pkg::*;

    // two frames for sync, two per image check, plus downloads and slack
    localparam int max_cycles = 45000;

    logic       clk;
    logic       arst_n;
    logic       downloading;
    ioctl_t     ioctl;
    logic       pix_cen;
    video_t     video;
    frame_t     frame_cnt;
    logic       led;

    int         seed;
    int         errors;
    int         tests_run;
    int         cycles;
    byte_t      model [tile_depth];
    dl_addr_t   wr_addr_q [$];
    byte_t      wr_data_q [$];

    game_video_top dut0 (
        .clk         ( clk         ),
        .arst_n      ( arst_n      ),
        .downloading ( downloading ),
        .ioctl       ( ioctl       ),
        .pix_cen     ( pix_cen     ),
        .video       ( video       ),
        .frame_cnt   ( frame_cnt   ),
        .led         ( led         )
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("timeout after %0d cycles, a test never finished", cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    task automatic report_mismatch(input string name, input int expected, input int actual);
        errors++;
        $display("[FAIL] t=%0t %s expected %0d actual %0d", $time, name, expected, actual);
    endtask

    // outputs expected while a download runs
    task automatic check_session_outputs();
        if (video.red != '0) report_mismatch("video.red", 0, int'(video.red));
        if (video.green != '0) report_mismatch("video.green", 0, int'(video.green));
        if (video.blue != '0) report_mismatch("video.blue", 0, int'(video.blue));
        if (led) report_mismatch("led", 0, 1);
    endtask

    // returns at the first negedge showing the next output pixel
    task automatic wait_pixel();
        while (!pix_cen) @(negedge clk);
        @(negedge clk);
    endtask

    task automatic reset_test();
        tests_run++;
        @(negedge clk);
        if (pix_cen) report_mismatch("pix_cen", 0, 1);
        if (video.hs) report_mismatch("video.hs", 0, 1);
        if (video.vs) report_mismatch("video.vs", 0, 1);
        if (!video.blank) report_mismatch("video.blank", 1, 0);
        if (video.red != '0) report_mismatch("video.red", 0, int'(video.red));
        if (video.green != '0) report_mismatch("video.green", 0, int'(video.green));
        if (video.blue != '0) report_mismatch("video.blue", 0, int'(video.blue));
        if (led) report_mismatch("led", 0, 1);
        if (frame_cnt != '0) report_mismatch("frame_cnt", 0, int'(frame_cnt));
    endtask

    // distances counted in pixel enables between sync edges
    task automatic sync_test();
        int     n;
        int     hs_rise;
        int     vs_rise;
        int     vs_seen;
        logic   hs_q;
        logic   vs_q;
        frame_t f0;
        tests_run++;
        n = 0;
        hs_rise = -1;
        vs_rise = -1;
        vs_seen = 0;
        f0 = '0;
        hs_q = video.hs;
        vs_q = video.vs;
        while (vs_seen < 2) begin
            wait_pixel();
            n++;
            if (video.hs && !hs_q) begin
                if (hs_rise >= 0 && n - hs_rise != h_total)
                    report_mismatch("video.hs period", h_total, n - hs_rise);
                hs_rise = n;
            end
            if (!video.hs && hs_q && hs_rise >= 0 && n - hs_rise != hs_end - hs_start)
                report_mismatch("video.hs width", hs_end - hs_start, n - hs_rise);
            if (video.vs && !vs_q) begin
                if (vs_rise >= 0 && n - vs_rise != v_total * h_total)
                    report_mismatch("video.vs period", v_total * h_total, n - vs_rise);
                if (vs_rise >= 0 && frame_cnt != f0 + 1'b1)
                    report_mismatch("frame_cnt", int'(f0 + 1'b1), int'(frame_cnt));
                vs_rise = n;
                f0 = frame_cnt;
                vs_seen++;
            end
            if (!video.vs && vs_q && vs_rise >= 0 && n - vs_rise != (vs_end - vs_start) * h_total)
                report_mismatch("video.vs width", (vs_end - vs_start) * h_total, n - vs_rise);
            hs_q = video.hs;
            vs_q = video.vs;
        end
    endtask

    // writes the queued bytes while the picture must stay black
    task automatic download();
        int i;
        tests_run++;
        @(posedge clk);
        downloading <= 1'b1;
        repeat (4) @(posedge clk);
        for (i = 0; i < wr_addr_q.size(); i++) begin
            ioctl.wr   <= 1'b1;
            ioctl.addr <= wr_addr_q[i];
            ioctl.data <= wr_data_q[i];
            @(negedge clk);
            check_session_outputs();
            @(posedge clk);
        end
        ioctl.wr <= 1'b0;
        // stay in the session until a visible line has gone by
        do begin
            @(negedge clk);
            check_session_outputs();
        end while (video.blank);
        for (i = 0; i < cen_div * h_visible; i++) begin
            @(negedge clk);
            check_session_outputs();
        end
        @(posedge clk);
        downloading <= 1'b0;
        @(negedge clk);
        for (i = 0; i < 8 && !led; i++) @(negedge clk);
        if (!led) begin
            errors++;
            $display("error at %0t: led did not rise after the download ended", $time);
        end
        wr_addr_q.delete();
        wr_data_q.delete();
    endtask

    // one whole frame, starting at the output pixel where vs falls
    task automatic frame_test();
        int     h;
        int     v;
        int     k;
        logic   vs_q;
        logic   visible;
        logic   exp_hs;
        logic   exp_vs;
        byte_t  b;
        color_t exp_r;
        color_t exp_g;
        color_t exp_b;
        tests_run++;
        do begin
            vs_q = video.vs;
            wait_pixel();
        end while (!(vs_q && !video.vs));
        h = 0;
        v = vs_end;
        for (k = 0; k < h_total * v_total; k++) begin
            visible = h < h_visible && v < v_visible;
            b = model[tile_addr_t'((v / 4) * 16 + h / 4)];
            exp_r = visible ? b[7:4] : '0;
            exp_g = visible ? b[3:0] : '0;
            exp_b = visible ? b[5:2] : '0;
            exp_hs = h >= hs_start && h < hs_end;
            exp_vs = v >= vs_start && v < vs_end;
            if (video.hs != exp_hs) report_mismatch("video.hs", int'(exp_hs), int'(video.hs));
            if (video.vs != exp_vs) report_mismatch("video.vs", int'(exp_vs), int'(video.vs));
            if (video.blank == visible)
                report_mismatch("video.blank", int'(!visible), int'(video.blank));
            if (video.red != exp_r) report_mismatch("video.red", int'(exp_r), int'(video.red));
            if (video.green != exp_g)
                report_mismatch("video.green", int'(exp_g), int'(video.green));
            if (video.blue != exp_b) report_mismatch("video.blue", int'(exp_b), int'(video.blue));
            wait_pixel();
            h++;
            if (h == h_total) begin
                h = 0;
                v = (v + 1) % v_total;
            end
        end
    endtask

    initial begin
        int         i;
        tile_addr_t tile;
        seed = 78614;
        errors = 0;
        tests_run = 0;
        cycles = 0;
        arst_n <= 1'b0;
        downloading <= 1'b0;
        ioctl <= '0;
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;

        reset_test();
        sync_test();

        for (i = 0; i < 128; i++) begin
            model[tile_addr_t'(i)] = byte_t'($random(seed));
            wr_addr_q.push_back(dl_addr_t'(i));
            wr_data_q.push_back(model[tile_addr_t'(i)]);
        end
        download();
        frame_test();

        // out of range bytes around one real tile write
        tile = 8'd37;
        for (i = 0; i < 8; i++) begin
            if (i == 4) begin
                model[tile] = model[tile] ^ byte_t'($random(seed) | 1);
                wr_addr_q.push_back(dl_addr_t'(tile));
                wr_data_q.push_back(model[tile]);
            end
            wr_addr_q.push_back(dl_addr_t'(tile_depth + i * 64));
            wr_data_q.push_back(byte_t'($random(seed)));
        end
        download();
        frame_test();

        $display("tests run %0d, errors %0d", tests_run, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* logic/game_video_top.sv */
`timescale 1ns/100ps

module game_video_top (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              downloading,
    input  dl_pkg::ioctl_t    ioctl,
    output logic              pix_cen,
    output video_pkg::video_t video,
    output video_pkg::frame_t frame_cnt,
    output logic              led
);
    import video_pkg::*;
    import dl_pkg::*;

    raster_t    raster;
    tile_addr_t rd_addr;
    byte_t      rd_data;
    logic       busy;

    rom_loader u_loader (
        .clk         ( clk         ),
        .arst_n      ( arst_n      ),
        .downloading ( downloading ),
        .ioctl       ( ioctl       ),
        .rd_addr     ( rd_addr     ),
        .rd_data     ( rd_data     ),
        .busy        ( busy        ),
        .loaded      ( led         )
    );

    video_timer u_timer (
        .clk         ( clk         ),
        .arst_n      ( arst_n      ),
        .pix_cen     ( pix_cen     ),
        .raster      ( raster      ),
        .frame_cnt   ( frame_cnt   )
    );

    pixel_mux u_pixel (
        .clk         ( clk         ),
        .arst_n      ( arst_n      ),
        .pix_cen     ( pix_cen     ),
        .raster      ( raster      ),
        .busy        ( busy        ),
        .rd_addr     ( rd_addr     ),
        .rd_data     ( rd_data     ),
        .video       ( video       )
    );

endmodule

/* logic/pixel_mux.sv */
`timescale 1ns/100ps

module pixel_mux (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               pix_cen,
    input  video_pkg::raster_t raster,
    input  logic               busy,
    output dl_pkg::tile_addr_t rd_addr,
    input  dl_pkg::byte_t      rd_data,
    output video_pkg::video_t  video
);
    import video_pkg::*;
    import dl_pkg::*;

    logic   dark;
    color_t red_nxt;
    color_t green_nxt;
    color_t blue_nxt;

    // 16 tiles per row, each 4x4 pixels
    assign rd_addr = tile_addr_t'({raster.v[5:2], raster.h[5:2]});

    assign dark = raster.blank || busy;

    always_comb begin
        red_nxt   = '0;
        green_nxt = '0;
        blue_nxt  = '0;
        if (!dark) begin
            red_nxt   = rd_data[7:4];
            green_nxt = rd_data[3:0];
            blue_nxt  = rd_data[5:2];
        end
    end

    // rd_data settles one clk before the next pixel enable
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            video.hs    <= 1'b0;
            video.vs    <= 1'b0;
            video.blank <= 1'b1;
            video.red   <= '0;
            video.green <= '0;
            video.blue  <= '0;
        end else if (pix_cen) begin
            video.hs    <= raster.hs;
            video.vs    <= raster.vs;
            video.blank <= raster.blank;
            video.red   <= red_nxt;
            video.green <= green_nxt;
            video.blue  <= blue_nxt;
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n)
        video.blank |-> video.red == '0 && video.green == '0 && video.blue == '0);

endmodule

/* logic/video_timer.sv */
`timescale 1ns/100ps

module video_timer (
    input  logic               clk,
    input  logic               arst_n,
    output logic               pix_cen,
    output video_pkg::raster_t raster,
    output video_pkg::frame_t  frame_cnt
);
    import video_pkg::*;

    cen_t  cen_cnt;
    hcnt_t h_nxt;
    vcnt_t v_nxt;
    logic  h_wrap;
    logic  v_wrap;

    // pixel enable, one clk in cen_div
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cen_cnt <= '0;
        end else if (pix_cen) begin
            cen_cnt <= '0;
        end else begin
            cen_cnt <= cen_cnt + 1'b1;
        end
    end

    assign pix_cen = cen_cnt == cen_t'(cen_div - 1);

    always_comb begin
        h_wrap = raster.h == hcnt_t'(h_total - 1);
        v_wrap = raster.v == vcnt_t'(v_total - 1);
        h_nxt  = h_wrap ? '0 : raster.h + 1'b1;
        v_nxt  = raster.v;
        if (h_wrap) begin
            v_nxt = v_wrap ? '0 : raster.v + 1'b1;
        end
    end

    // sync and blank follow the new counter values
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            raster.h     <= '0;
            raster.v     <= '0;
            raster.hs    <= 1'b0;
            raster.vs    <= 1'b0;
            raster.blank <= 1'b1;
        end else if (pix_cen) begin
            raster.h     <= h_nxt;
            raster.v     <= v_nxt;
            raster.hs    <= h_nxt >= hcnt_t'(hs_start) && h_nxt < hcnt_t'(hs_end);
            raster.vs    <= v_nxt >= vcnt_t'(vs_start) && v_nxt < vcnt_t'(vs_end);
            raster.blank <= h_nxt >= hcnt_t'(h_visible) || v_nxt >= vcnt_t'(v_visible);
        end
    end

    // counts at the start of vertical sync
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            frame_cnt <= '0;
        end else if (pix_cen && h_wrap && v_nxt == vcnt_t'(vs_start)) begin
            frame_cnt <= frame_cnt + 1'b1;
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n)
        int'(raster.h) < h_total && int'(raster.v) < v_total);

endmodule

/* logic/rom_loader.sv */
`timescale 1ns/100ps

module rom_loader (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               downloading,
    input  dl_pkg::ioctl_t     ioctl,
    input  dl_pkg::tile_addr_t rd_addr,
    output dl_pkg::byte_t      rd_data,
    output logic               busy,
    output logic               loaded
);
    import dl_pkg::*;

    byte_t mem [tile_depth];
    logic  in_range;
    logic  wr_en;
    logic  session_start;
    logic  session_end;
    logic  wrote;

    assign in_range      = ioctl.addr < dl_addr_t'(tile_depth);
    assign wr_en         = ioctl.wr && in_range;
    assign session_start = downloading && !busy;
    assign session_end   = busy && !downloading;

    // out of range writes are dropped
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[tile_addr_t'(ioctl.addr)] <= ioctl.data;
        end
    end

    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy <= 1'b0;
        end else begin
            busy <= downloading;
        end
    end

    // session bookkeeping
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wrote  <= 1'b0;
            loaded <= 1'b0;
        end else if (session_start) begin
            // first byte may come on the same edge
            wrote  <= wr_en;
            loaded <= 1'b0;
        end else begin
            if (wr_en) begin
                wrote <= 1'b1;
            end
            if (session_end && wrote) begin
                loaded <= 1'b1;
            end
        end
    end

    // writes only inside a download session
    assert property (@(posedge clk) disable iff (!arst_n)
        ioctl.wr |-> downloading);

endmodule

/* logic/dl_pkg.sv */
package dl_pkg;

    // tile memory size in bytes
    localparam int tile_depth = 256;

    typedef logic [21:0] dl_addr_t;
    typedef logic [7:0]  byte_t;
    typedef logic [7:0]  tile_addr_t;

    // one byte per cycle with wr high
    typedef struct packed {
        logic     wr;
        dl_addr_t addr;
        byte_t    data;
    } ioctl_t;

endpackage

/* logic/video_pkg.sv */
package video_pkg;

    // horizontal timing in pixels, end of sync exclusive
    localparam int h_total   = 64;
    localparam int h_visible = 48;
    localparam int hs_start  = 52;
    localparam int hs_end    = 58;

    // vertical timing in lines
    localparam int v_total   = 40;
    localparam int v_visible = 32;
    localparam int vs_start  = 34;
    localparam int vs_end    = 36;

    // clk cycles per pixel
    localparam int cen_div = 2;

    typedef logic [$clog2(cen_div)-1:0] cen_t;
    typedef logic [5:0]                 hcnt_t;
    typedef logic [5:0]                 vcnt_t;
    typedef logic [3:0]                 color_t;
    typedef logic [31:0]                frame_t;

    // raw raster from the timer
    typedef struct packed {
        hcnt_t h;
        vcnt_t v;
        logic  hs;
        logic  vs;
        logic  blank;
    } raster_t;

    // registered video out
    typedef struct packed {
        logic   hs;
        logic   vs;
        logic   blank;
        color_t red;
        color_t green;
        color_t blue;
    } video_t;

endpackage
